//--- rtl/pcie_config_defines.svh
`ifndef PCIE_CONFIG_DEFINES_SVH
`define PCIE_CONFIG_DEFINES_SVH

// Bus and payload widths
`define AXIL_DATA_W       32
`define AXIL_STRB_W       4
`define AXIL_ADDR_W       32
`define CSR_OFS_W         16
`define PCIE_ADDR_W       64
`define RAM_ADDR_W        32
`define DMA_LEN_W         16
`define DMA_TAG_W         32
`define FLASH_ADDR_W      23
`define FLASH_DQ_W        16

// Identification words
`define FW_ID             32'h0000_0000
`define FW_VER            32'h0000_0001
`define BOARD_ID          32'h1ce4_0003
`define BOARD_VER         32'h0000_0001
`define FPGA_ID           32'h0382_3093
`define FLASH_ID          32'h1810_0201   // Width 24, 16 bit bus, 2 banks, 1 region

// Address space layout
`define IF_COUNT          32'h0000_0002
`define IF_STRIDE         32'h8000_0000
`define IF_CTRL_OFFSET    32'h0400_0000
`define PHC_OFFSET        32'h0000_0200
`define PHC_STRIDE        32'h0000_0080

// Register offsets
`define REG_GPIO_OUT      16'h0100
`define REG_GPIO_IN       16'h0104
`define REG_FLASH_ID      16'h0140
`define REG_FLASH_ADDR    16'h0144
`define REG_FLASH_DQ      16'h0148
`define REG_FLASH_CTRL    16'h014C
`define DMA_RD_BASE       16'h0440
`define DMA_WR_BASE       16'h0460

// Offsets inside one DMA channel
`define DMA_PCIE_ADDR_LO  16'h0000
`define DMA_PCIE_ADDR_HI  16'h0004
`define DMA_RAM_ADDR      16'h0008
`define DMA_LEN           16'h0010
`define DMA_TAG           16'h0014
`define DMA_STATUS        16'h0018

`endif

//--- rtl/pcie_config_pkg.sv
`include "pcie_config_defines.svh"

package pcie_config_pkg;

  // One accepted register write
  typedef struct packed {
    logic [`CSR_OFS_W-1:0]   ofs;
    logic [`AXIL_DATA_W-1:0] data;
    logic [`AXIL_STRB_W-1:0] strb;
  } csr_wr_t;

  // SFP and EEPROM I2C lines
  typedef struct packed {
    logic sfp_scl;
    logic sfp1_sda;
    logic sfp2_sda;
    logic eeprom_scl;
    logic eeprom_sda;
  } i2c_pins_t;

  // BPI flash outputs, strobes active low
  typedef struct packed {
    logic [`FLASH_DQ_W-1:0]   dq_o;
    logic                     dq_oe;
    logic [`FLASH_ADDR_W-1:0] addr;
    logic                     region;    // Address bit 23
    logic                     region_oe;
    logic                     ce_n;
    logic                     oe_n;
    logic                     we_n;
    logic                     adv_n;
  } flash_out_t;

  // Host DMA descriptor
  typedef struct packed {
    logic [`PCIE_ADDR_W-1:0] pcie_addr;
    logic [`RAM_ADDR_W-1:0]  ram_addr;
    logic [`DMA_LEN_W-1:0]   len;
    logic [`DMA_TAG_W-1:0]   tag;
  } dma_desc_t;

endpackage

//--- rtl/csr_axil_slave.sv
`include "pcie_config_defines.svh"

module csr_axil_slave (
  input  logic                       pcie_clk,
  input  logic                       pcie_rst,

  input  logic [`AXIL_ADDR_W-1:0]    awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [`AXIL_DATA_W-1:0]    wdata_i,
  input  logic [`AXIL_STRB_W-1:0]    wstrb_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output logic [1:0]                 bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  input  logic [`AXIL_ADDR_W-1:0]    araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic [`AXIL_DATA_W-1:0]    rdata_o,
  output logic [1:0]                 rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,

  output pcie_config_pkg::csr_wr_t   wr_o,
  output logic                       wr_valid_o,
  output logic [`CSR_OFS_W-1:0]      rd_ofs_o,
  output logic                       rd_valid_o,
  input  logic [`AXIL_DATA_W-1:0]    io_rdata_i,
  input  logic [`AXIL_DATA_W-1:0]    dma_rd_rdata_i,
  input  logic [`AXIL_DATA_W-1:0]    dma_wr_rdata_i
);

  logic                    wr_accept;
  logic                    rd_accept;
  logic [`AXIL_DATA_W-1:0] id_rdata;

  assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;
  assign rd_accept = arvalid_i && !rvalid_o;

  assign bresp_o = 2'b00;
  assign rresp_o = 2'b00;

  // Word aligned offsets
  assign wr_o.ofs   = {awaddr_i[`CSR_OFS_W-1:2], 2'b00};
  assign wr_o.data  = wdata_i;
  assign wr_o.strb  = wstrb_i;
  assign wr_valid_o = wr_accept;

  assign rd_ofs_o   = {araddr_i[`CSR_OFS_W-1:2], 2'b00};
  assign rd_valid_o = rd_accept;

  always_comb begin
    id_rdata = '0;
    case (rd_ofs_o)
      16'h0000:      id_rdata = `FW_ID;
      16'h0004:      id_rdata = `FW_VER;
      16'h0008:      id_rdata = `BOARD_ID;
      16'h000C:      id_rdata = `BOARD_VER;
      16'h0014:      id_rdata = `PHC_OFFSET;  // PHC count at 0x10 stays zero
      16'h0018:      id_rdata = `PHC_STRIDE;
      16'h0020:      id_rdata = `IF_COUNT;
      16'h0024:      id_rdata = `IF_STRIDE;
      16'h002C:      id_rdata = `IF_CTRL_OFFSET;
      16'h0040:      id_rdata = `FPGA_ID;
      `REG_FLASH_ID: id_rdata = `FLASH_ID;
      default:       id_rdata = '0;
    endcase
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      awready_o <= wr_accept;
      wready_o  <= wr_accept;
      bvalid_o  <= wr_accept || (bvalid_o && !bready_i);
      arready_o <= rd_accept;
      rvalid_o  <= rd_accept || (rvalid_o && !rready_i);
    end
  end

  // Blocks return zero for offsets they do not own
  always_ff @(posedge pcie_clk) begin
    if (rd_accept) begin
      rdata_o <= id_rdata | io_rdata_i | dma_rd_rdata_i | dma_wr_rdata_i;
    end
  end

  // No new write while a response is outstanding
  a_no_aw_during_b: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    bvalid_o |=> !awready_o);

  a_rdata_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rvalid_o && !rready_i |=> $stable(rdata_o));

endmodule

//--- rtl/board_io_regs.sv
`include "pcie_config_defines.svh"

module board_io_regs (
  input  logic                         pcie_clk,
  input  logic                         pcie_rst,

  input  pcie_config_pkg::csr_wr_t     wr_i,
  input  logic                         wr_valid_i,
  input  logic [`CSR_OFS_W-1:0]        rd_ofs_i,
  output logic [`AXIL_DATA_W-1:0]      rdata_o,

  input  pcie_config_pkg::i2c_pins_t   i2c_in_i,
  input  logic [`FLASH_DQ_W-1:0]       flash_dq_i,
  output pcie_config_pkg::i2c_pins_t   i2c_o,
  output pcie_config_pkg::flash_out_t  flash_o
);

  // Chip deselected, bus released
  localparam pcie_config_pkg::flash_out_t FLASH_IDLE = '{
    dq_o:      '0,
    dq_oe:     1'b0,
    addr:      '0,
    region:    1'b0,
    region_oe: 1'b0,
    ce_n:      1'b1,
    oe_n:      1'b1,
    we_n:      1'b1,
    adv_n:     1'b1
  };

  pcie_config_pkg::i2c_pins_t  gpio_q;
  pcie_config_pkg::flash_out_t flash_q;
  pcie_config_pkg::i2c_pins_t  i2c_in_q;
  logic [`FLASH_DQ_W-1:0]      flash_dq_q;

  // GPIO word layout, SFP in byte 2 and EEPROM in byte 3
  function automatic logic [`AXIL_DATA_W-1:0] gpio_word(input pcie_config_pkg::i2c_pins_t p);
    logic [`AXIL_DATA_W-1:0] w;
    w     = '0;
    w[16] = p.sfp_scl;
    w[17] = p.sfp1_sda;
    w[18] = p.sfp2_sda;
    w[24] = p.eeprom_scl;
    w[25] = p.eeprom_sda;
    return w;
  endfunction

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      gpio_q  <= '1;
      flash_q <= FLASH_IDLE;
    end else if (wr_valid_i) begin
      case (wr_i.ofs)
        `REG_GPIO_OUT: begin
          if (wr_i.strb[2]) begin
            gpio_q.sfp_scl  <= wr_i.data[16];
            gpio_q.sfp1_sda <= wr_i.data[17];
            gpio_q.sfp2_sda <= wr_i.data[18];
          end
          if (wr_i.strb[3]) begin
            gpio_q.eeprom_scl <= wr_i.data[24];
            gpio_q.eeprom_sda <= wr_i.data[25];
          end
        end
        `REG_FLASH_ADDR: begin
          flash_q.addr   <= wr_i.data[`FLASH_ADDR_W-1:0];
          flash_q.region <= wr_i.data[`FLASH_ADDR_W];
        end
        `REG_FLASH_DQ: flash_q.dq_o <= wr_i.data[`FLASH_DQ_W-1:0];
        `REG_FLASH_CTRL: begin
          if (wr_i.strb[0]) begin
            flash_q.ce_n  <= wr_i.data[0];
            flash_q.oe_n  <= wr_i.data[1];
            flash_q.we_n  <= wr_i.data[2];
            flash_q.adv_n <= wr_i.data[3];
          end
          if (wr_i.strb[1]) begin
            flash_q.dq_oe <= wr_i.data[8];
          end
          if (wr_i.strb[2]) begin
            flash_q.region_oe <= wr_i.data[16];
          end
        end
        default: ;
      endcase
    end
  end

  // Pin stage and input sampling, one register each way
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      i2c_o      <= '1;
      flash_o    <= FLASH_IDLE;
      i2c_in_q   <= '1;
      flash_dq_q <= '0;
    end else begin
      i2c_o      <= gpio_q;
      flash_o    <= flash_q;
      i2c_in_q   <= i2c_in_i;
      flash_dq_q <= flash_dq_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (rd_ofs_i)
      `REG_GPIO_OUT:   rdata_o = gpio_word(gpio_q);
      `REG_GPIO_IN:    rdata_o = gpio_word(i2c_in_q);
      `REG_FLASH_ADDR: begin
        rdata_o[`FLASH_ADDR_W-1:0] = flash_q.addr;
        rdata_o[`FLASH_ADDR_W]     = flash_q.region;
      end
      `REG_FLASH_DQ:   rdata_o[`FLASH_DQ_W-1:0] = flash_dq_q;  // Pin value, not register
      `REG_FLASH_CTRL: begin
        rdata_o[0]  = flash_q.ce_n;
        rdata_o[1]  = flash_q.oe_n;
        rdata_o[2]  = flash_q.we_n;
        rdata_o[3]  = flash_q.adv_n;
        rdata_o[8]  = flash_q.dq_oe;
        rdata_o[16] = flash_q.region_oe;
      end
      default:         rdata_o = '0;
    endcase
  end

endmodule

//--- rtl/host_dma_channel.sv
`include "pcie_config_defines.svh"

module host_dma_channel #(
  parameter logic [`CSR_OFS_W-1:0] REG_BASE = `DMA_RD_BASE
) (
  input  logic                        pcie_clk,
  input  logic                        pcie_rst,

  input  pcie_config_pkg::csr_wr_t    wr_i,
  input  logic                        wr_valid_i,
  input  logic [`CSR_OFS_W-1:0]       rd_ofs_i,
  input  logic                        rd_valid_i,
  output logic [`AXIL_DATA_W-1:0]     rdata_o,

  output pcie_config_pkg::dma_desc_t  desc_o,
  output logic                        desc_valid_o,
  input  logic                        desc_ready_i,
  input  logic [`DMA_TAG_W-1:0]       status_tag_i,
  input  logic                        status_valid_i
);

  localparam logic [`CSR_OFS_W-1:0] OFS_ADDR_LO = REG_BASE + `DMA_PCIE_ADDR_LO;
  localparam logic [`CSR_OFS_W-1:0] OFS_ADDR_HI = REG_BASE + `DMA_PCIE_ADDR_HI;
  localparam logic [`CSR_OFS_W-1:0] OFS_RAM     = REG_BASE + `DMA_RAM_ADDR;
  localparam logic [`CSR_OFS_W-1:0] OFS_LEN     = REG_BASE + `DMA_LEN;
  localparam logic [`CSR_OFS_W-1:0] OFS_TAG     = REG_BASE + `DMA_TAG;
  localparam logic [`CSR_OFS_W-1:0] OFS_STATUS  = REG_BASE + `DMA_STATUS;

  logic                  tag_wr;
  logic                  status_rd;
  logic [`DMA_TAG_W-1:0] tags_q;

  assign tag_wr    = wr_valid_i && (wr_i.ofs == OFS_TAG);
  assign status_rd = rd_valid_i && (rd_ofs_i == OFS_STATUS);

  always_ff @(posedge pcie_clk) begin
    if (wr_valid_i) begin
      case (wr_i.ofs)
        OFS_ADDR_LO: desc_o.pcie_addr[31:0]              <= wr_i.data;
        OFS_ADDR_HI: desc_o.pcie_addr[`PCIE_ADDR_W-1:32] <= wr_i.data;
        OFS_RAM:     desc_o.ram_addr                     <= wr_i.data[`RAM_ADDR_W-1:0];
        OFS_LEN:     desc_o.len                          <= wr_i.data[`DMA_LEN_W-1:0];
        OFS_TAG:     desc_o.tag                          <= wr_i.data[`DMA_TAG_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      desc_valid_o <= 1'b0;
      tags_q       <= '0;
    end else begin
      desc_valid_o <= tag_wr || (desc_valid_o && !desc_ready_i);  // Tag write issues
      if (status_rd) begin
        // Read clears, a tag in the same cycle survives
        tags_q <= status_valid_i ? status_tag_i : '0;
      end else if (status_valid_i) begin
        tags_q <= tags_q | status_tag_i;
      end
    end
  end

  assign rdata_o = (rd_ofs_i == OFS_STATUS) ? tags_q : '0;

  a_desc_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    desc_valid_o && !desc_ready_i |=> $stable(desc_o));

endmodule

//--- rtl/pcie_config.sv
`include "pcie_config_defines.svh"

module pcie_config (
  input  logic                         pcie_clk,
  input  logic                         pcie_rst,

  // AXI-lite control
  input  logic [`AXIL_ADDR_W-1:0]      s_axil_awaddr_i,
  input  logic                         s_axil_awvalid_i,
  output logic                         s_axil_awready_o,
  input  logic [`AXIL_DATA_W-1:0]      s_axil_wdata_i,
  input  logic [`AXIL_STRB_W-1:0]      s_axil_wstrb_i,
  input  logic                         s_axil_wvalid_i,
  output logic                         s_axil_wready_o,
  output logic [1:0]                   s_axil_bresp_o,
  output logic                         s_axil_bvalid_o,
  input  logic                         s_axil_bready_i,
  input  logic [`AXIL_ADDR_W-1:0]      s_axil_araddr_i,
  input  logic                         s_axil_arvalid_i,
  output logic                         s_axil_arready_o,
  output logic [`AXIL_DATA_W-1:0]      s_axil_rdata_o,
  output logic [1:0]                   s_axil_rresp_o,
  output logic                         s_axil_rvalid_o,
  input  logic                         s_axil_rready_i,

  // Board pins
  input  pcie_config_pkg::i2c_pins_t   i2c_in_i,
  output pcie_config_pkg::i2c_pins_t   i2c_o,
  input  logic [`FLASH_DQ_W-1:0]       flash_dq_i,
  output pcie_config_pkg::flash_out_t  flash_o,

  // Host DMA read channel
  output pcie_config_pkg::dma_desc_t   dma_rd_desc_o,
  output logic                         dma_rd_desc_valid_o,
  input  logic                         dma_rd_desc_ready_i,
  input  logic [`DMA_TAG_W-1:0]        dma_rd_status_tag_i,
  input  logic                         dma_rd_status_valid_i,

  // Host DMA write channel
  output pcie_config_pkg::dma_desc_t   dma_wr_desc_o,
  output logic                         dma_wr_desc_valid_o,
  input  logic                         dma_wr_desc_ready_i,
  input  logic [`DMA_TAG_W-1:0]        dma_wr_status_tag_i,
  input  logic                         dma_wr_status_valid_i
);

  pcie_config_pkg::csr_wr_t wr;
  logic                     wr_valid;
  logic [`CSR_OFS_W-1:0]    rd_ofs;
  logic                     rd_valid;
  logic [`AXIL_DATA_W-1:0]  io_rdata;
  logic [`AXIL_DATA_W-1:0]  dma_rd_rdata;
  logic [`AXIL_DATA_W-1:0]  dma_wr_rdata;

  csr_axil_slave u_slave (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .awaddr_i       (s_axil_awaddr_i),
    .awvalid_i      (s_axil_awvalid_i),
    .awready_o      (s_axil_awready_o),
    .wdata_i        (s_axil_wdata_i),
    .wstrb_i        (s_axil_wstrb_i),
    .wvalid_i       (s_axil_wvalid_i),
    .wready_o       (s_axil_wready_o),
    .bresp_o        (s_axil_bresp_o),
    .bvalid_o       (s_axil_bvalid_o),
    .bready_i       (s_axil_bready_i),
    .araddr_i       (s_axil_araddr_i),
    .arvalid_i      (s_axil_arvalid_i),
    .arready_o      (s_axil_arready_o),
    .rdata_o        (s_axil_rdata_o),
    .rresp_o        (s_axil_rresp_o),
    .rvalid_o       (s_axil_rvalid_o),
    .rready_i       (s_axil_rready_i),
    .wr_o           (wr),
    .wr_valid_o     (wr_valid),
    .rd_ofs_o       (rd_ofs),
    .rd_valid_o     (rd_valid),
    .io_rdata_i     (io_rdata),
    .dma_rd_rdata_i (dma_rd_rdata),
    .dma_wr_rdata_i (dma_wr_rdata)
  );

  board_io_regs u_board_io (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .wr_i       (wr),
    .wr_valid_i (wr_valid),
    .rd_ofs_i   (rd_ofs),
    .rdata_o    (io_rdata),
    .i2c_in_i   (i2c_in_i),
    .flash_dq_i (flash_dq_i),
    .i2c_o      (i2c_o),
    .flash_o    (flash_o)
  );

  host_dma_channel #(.REG_BASE(`DMA_RD_BASE)) u_dma_rd (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .wr_i           (wr),
    .wr_valid_i     (wr_valid),
    .rd_ofs_i       (rd_ofs),
    .rd_valid_i     (rd_valid),
    .rdata_o        (dma_rd_rdata),
    .desc_o         (dma_rd_desc_o),
    .desc_valid_o   (dma_rd_desc_valid_o),
    .desc_ready_i   (dma_rd_desc_ready_i),
    .status_tag_i   (dma_rd_status_tag_i),
    .status_valid_i (dma_rd_status_valid_i)
  );

  host_dma_channel #(.REG_BASE(`DMA_WR_BASE)) u_dma_wr (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .wr_i           (wr),
    .wr_valid_i     (wr_valid),
    .rd_ofs_i       (rd_ofs),
    .rd_valid_i     (rd_valid),
    .rdata_o        (dma_wr_rdata),
    .desc_o         (dma_wr_desc_o),
    .desc_valid_o   (dma_wr_desc_valid_o),
    .desc_ready_i   (dma_wr_desc_ready_i),
    .status_tag_i   (dma_wr_status_tag_i),
    .status_valid_i (dma_wr_status_valid_i)
  );

endmodule

//--- dv/pcie_config_tb.sv
`include "pcie_config_defines.svh"

module pcie_config_tb;

  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DLY  = 2;
  localparam int N_GPIO     = 16;
  localparam int N_FLASH    = 8;
  localparam int N_DESC     = 4;
  localparam int N_STAT     = 4;
  // Bus transactions over the whole run
  localparam int NUM_TXN = 21 + 3 * N_GPIO + 6 * N_FLASH + 10 * N_DESC + 4 * N_STAT + 3;

  logic                              pcie_clk = 1'b0;
  logic                              pcie_rst;
  logic [`AXIL_ADDR_W-1:0]           awaddr;
  logic                              awvalid;
  logic                              awready;
  logic [`AXIL_DATA_W-1:0]           wdata;
  logic [`AXIL_STRB_W-1:0]           wstrb;
  logic                              wvalid;
  logic                              wready;
  logic [1:0]                        bresp;
  logic                              bvalid;
  logic                              bready;
  logic [`AXIL_ADDR_W-1:0]           araddr;
  logic                              arvalid;
  logic                              arready;
  logic [`AXIL_DATA_W-1:0]           rdata;
  logic [1:0]                        rresp;
  logic                              rvalid;
  logic                              rready;
  pcie_config_pkg::i2c_pins_t        i2c_in;
  pcie_config_pkg::i2c_pins_t        i2c_o;
  logic [`FLASH_DQ_W-1:0]            flash_dq;
  pcie_config_pkg::flash_out_t       flash_o;
  pcie_config_pkg::dma_desc_t [1:0]  desc;        // Index 0 read channel and 1 write channel
  logic [1:0]                        desc_valid;
  logic [1:0]                        desc_ready = 2'b00;
  logic [1:0][`DMA_TAG_W-1:0]        status_tag;
  logic [1:0]                        status_valid;

  // Reference state
  pcie_config_pkg::i2c_pins_t        gpio_sh;
  pcie_config_pkg::flash_out_t       flash_sh;
  pcie_config_pkg::dma_desc_t        exp_desc [2];
  logic [`DMA_TAG_W-1:0]             tag_acc [2];
  int                                hs_count [2] = '{0, 0};
  logic [`AXIL_DATA_W-1:0]           exp_q [$];
  int unsigned                       seed_val;

  always #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;

  pcie_config DUT (
    .pcie_clk              (pcie_clk),
    .pcie_rst              (pcie_rst),
    .s_axil_awaddr_i       (awaddr),
    .s_axil_awvalid_i      (awvalid),
    .s_axil_awready_o      (awready),
    .s_axil_wdata_i        (wdata),
    .s_axil_wstrb_i        (wstrb),
    .s_axil_wvalid_i       (wvalid),
    .s_axil_wready_o       (wready),
    .s_axil_bresp_o        (bresp),
    .s_axil_bvalid_o       (bvalid),
    .s_axil_bready_i       (bready),
    .s_axil_araddr_i       (araddr),
    .s_axil_arvalid_i      (arvalid),
    .s_axil_arready_o      (arready),
    .s_axil_rdata_o        (rdata),
    .s_axil_rresp_o        (rresp),
    .s_axil_rvalid_o       (rvalid),
    .s_axil_rready_i       (rready),
    .i2c_in_i              (i2c_in),
    .i2c_o                 (i2c_o),
    .flash_dq_i            (flash_dq),
    .flash_o               (flash_o),
    .dma_rd_desc_o         (desc[0]),
    .dma_rd_desc_valid_o   (desc_valid[0]),
    .dma_rd_desc_ready_i   (desc_ready[0]),
    .dma_rd_status_tag_i   (status_tag[0]),
    .dma_rd_status_valid_i (status_valid[0]),
    .dma_wr_desc_o         (desc[1]),
    .dma_wr_desc_valid_o   (desc_valid[1]),
    .dma_wr_desc_ready_i   (desc_ready[1]),
    .dma_wr_status_tag_i   (status_tag[1]),
    .dma_wr_status_valid_i (status_valid[1])
  );

  task automatic check_eq(input string name, input logic [159:0] got,
                          input logic [159:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic next_slot();
    @(posedge pcie_clk);
    #DRIVE_DLY;
  endtask

  function automatic logic [31:0] gpio_layout(input pcie_config_pkg::i2c_pins_t p);
    return {6'b0, p.eeprom_sda, p.eeprom_scl, 5'b0, p.sfp2_sda, p.sfp1_sda, p.sfp_scl, 16'b0};
  endfunction

  function automatic void apply_write(input logic [15:0] ofs, input logic [31:0] d,
                                      input logic [3:0] s);
    case (ofs)
      `REG_GPIO_OUT: begin
        if (s[2]) begin
          gpio_sh.sfp_scl  = d[16];
          gpio_sh.sfp1_sda = d[17];
          gpio_sh.sfp2_sda = d[18];
        end
        if (s[3]) begin
          gpio_sh.eeprom_scl = d[24];
          gpio_sh.eeprom_sda = d[25];
        end
      end
      `REG_FLASH_ADDR: begin
        flash_sh.addr   = d[22:0];
        flash_sh.region = d[23];
      end
      `REG_FLASH_DQ: flash_sh.dq_o = d[15:0];   // Strobes ignored
      `REG_FLASH_CTRL: begin
        if (s[0]) begin
          flash_sh.ce_n  = d[0];
          flash_sh.oe_n  = d[1];
          flash_sh.we_n  = d[2];
          flash_sh.adv_n = d[3];
        end
        if (s[1]) flash_sh.dq_oe = d[8];
        if (s[2]) flash_sh.region_oe = d[16];
      end
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] expected_rdata(input logic [15:0] ofs);
    logic [31:0] w;
    w = '0;
    case (ofs)
      16'h0000:                       w = `FW_ID;
      16'h0004:                       w = `FW_VER;
      16'h0008:                       w = `BOARD_ID;
      16'h000C:                       w = `BOARD_VER;
      16'h0014:                       w = `PHC_OFFSET;
      16'h0018:                       w = `PHC_STRIDE;
      16'h0020:                       w = `IF_COUNT;
      16'h0024:                       w = `IF_STRIDE;
      16'h002C:                       w = `IF_CTRL_OFFSET;
      16'h0040:                       w = `FPGA_ID;
      `REG_FLASH_ID:                  w = `FLASH_ID;
      `REG_GPIO_OUT:                  w = gpio_layout(gpio_sh);
      `REG_GPIO_IN:                   w = gpio_layout(i2c_in);
      `REG_FLASH_ADDR:                w = {8'b0, flash_sh.region, flash_sh.addr};
      `REG_FLASH_DQ:                  w = {16'b0, flash_dq};
      `REG_FLASH_CTRL: begin
        w = {15'b0, flash_sh.region_oe, 7'b0, flash_sh.dq_oe, 4'b0,
             flash_sh.adv_n, flash_sh.we_n, flash_sh.oe_n, flash_sh.ce_n};
      end
      `DMA_RD_BASE + `DMA_STATUS:     w = tag_acc[0];
      `DMA_WR_BASE + `DMA_STATUS:     w = tag_acc[1];
      default:                        w = '0;
    endcase
    return w;
  endfunction

  task automatic axil_write(input logic [15:0] ofs, input logic [31:0] data,
                            input logic [3:0] strb);
    awaddr  = {16'h0, ofs};
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    do next_slot(); while (!awready);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check_eq("wready", 160'(wready), 160'(1));
    check_eq("bresp", 160'(bresp), 160'(0));
    do next_slot(); while (bvalid);
    apply_write(ofs, data, strb);
  endtask

  task automatic axil_read(input logic [15:0] ofs);
    exp_q.push_back(expected_rdata(ofs));
    if (ofs == `DMA_RD_BASE + `DMA_STATUS) tag_acc[0] = '0;
    if (ofs == `DMA_WR_BASE + `DMA_STATUS) tag_acc[1] = '0;
    araddr  = {16'h0, ofs};
    arvalid = 1'b1;
    rready  = 1'b1;
    do next_slot(); while (!arready);
    arvalid = 1'b0;
    do next_slot(); while (rvalid);
  endtask

  // Read data is stable mid-cycle ahead of the handshake edge
  always @(negedge pcie_clk) begin
    if (rvalid && rready) begin
      if (exp_q.size() == 0) begin
        $display("Read data returned while no read was outstanding");
        $display("STATUS: FAIL");
        $fatal(1, "unexpected read response");
      end
      check_eq("rdata", 160'(rdata), 160'(exp_q.pop_front()));
      check_eq("rresp", 160'(rresp), 160'(0));
    end
  end

  always @(negedge pcie_clk) begin
    if (desc_valid[0] && desc_ready[0]) begin
      hs_count[0] = hs_count[0] + 1;
      check_eq("dma_rd_desc_o", 160'(desc[0]), 160'(exp_desc[0]));
    end
    if (desc_valid[1] && desc_ready[1]) begin
      hs_count[1] = hs_count[1] + 1;
      check_eq("dma_wr_desc_o", 160'(desc[1]), 160'(exp_desc[1]));
    end
  end

  // Random back-pressure on both descriptor outputs
  always @(posedge pcie_clk) begin
    #DRIVE_DLY;
    desc_ready = 2'($urandom);
  end

  task automatic pulse_status(input logic ch, input logic [31:0] tag);
    status_tag[ch]   = tag;
    status_valid[ch] = 1'b1;
    next_slot();
    status_valid[ch] = 1'b0;
    tag_acc[ch] = tag_acc[ch] | tag;
  endtask

  task automatic gpio_test();
    logic [31:0] data;
    logic [3:0]  strb;
    for (int i = 0; i < N_GPIO; i++) begin
      data = $urandom;
      strb = 4'($urandom);
      axil_write(`REG_GPIO_OUT, data, strb);
      check_eq("i2c_o", 160'(i2c_o), 160'(gpio_sh));
      axil_read(`REG_GPIO_OUT);
      i2c_in = 5'($urandom);
      repeat (2) next_slot();
      axil_read(`REG_GPIO_IN);
    end
  endtask

  task automatic flash_test();
    for (int i = 0; i < N_FLASH; i++) begin
      axil_write(`REG_FLASH_ADDR, $urandom, 4'($urandom));
      axil_write(`REG_FLASH_DQ, $urandom, 4'($urandom));
      axil_write(`REG_FLASH_CTRL, $urandom, 4'($urandom));
      check_eq("flash_o", 160'(flash_o), 160'(flash_sh));
      axil_read(`REG_FLASH_ADDR);
      axil_read(`REG_FLASH_CTRL);
      flash_dq = 16'($urandom);
      repeat (2) next_slot();
      axil_read(`REG_FLASH_DQ);
    end
  endtask

  task automatic desc_test(input logic ch);
    logic [15:0]                base;
    int                         start;
    int                         other;
    pcie_config_pkg::dma_desc_t d;
    base = ch ? `DMA_WR_BASE : `DMA_RD_BASE;
    for (int i = 0; i < N_DESC; i++) begin
      d.pcie_addr  = {$urandom, $urandom};
      d.ram_addr   = $urandom;
      d.len        = 16'($urandom);
      d.tag        = $urandom;
      exp_desc[ch] = d;
      start        = hs_count[ch];
      other        = hs_count[!ch];
      axil_write(base + `DMA_PCIE_ADDR_LO, d.pcie_addr[31:0], 4'hf);
      axil_write(base + `DMA_PCIE_ADDR_HI, d.pcie_addr[63:32], 4'hf);
      axil_write(base + `DMA_RAM_ADDR, d.ram_addr, 4'hf);
      axil_write(base + `DMA_LEN, {16'h0, d.len}, 4'hf);
      axil_write(base + `DMA_TAG, d.tag, 4'hf);   // Issues the descriptor
      while (hs_count[ch] == start) next_slot();
      repeat (4) next_slot();
      check_eq("desc handshakes", 160'(hs_count[ch] - start), 160'(1));
      check_eq("other channel handshakes", 160'(hs_count[!ch] - other), 160'(0));
    end
  endtask

  task automatic status_test(input logic ch);
    logic [15:0] ofs;
    int unsigned n;
    ofs = (ch ? `DMA_WR_BASE : `DMA_RD_BASE) + `DMA_STATUS;
    for (int i = 0; i < N_STAT; i++) begin
      n = $urandom_range(0, 3);
      repeat (n) pulse_status(ch, $urandom);
      axil_read(ofs);
      if (i % 2 == 1) pulse_status(ch, $urandom);   // Late tag after the clearing read
      axil_read(ofs);
    end
  endtask

  // Second write waits behind an unacknowledged response
  task automatic blocked_write_test();
    logic [31:0] d1;
    logic [31:0] d2;
    d1      = $urandom;
    d2      = ~d1;
    awaddr  = {16'h0, `REG_FLASH_ADDR};
    wdata   = d1;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    do next_slot(); while (!awready);
    wdata = d2;
    repeat (5) begin
      next_slot();
      check_eq("bvalid", 160'(bvalid), 160'(1));
      check_eq("awready", 160'(awready), 160'(0));
      check_eq("wready", 160'(wready), 160'(0));
    end
    bready = 1'b1;
    do next_slot(); while (!awready);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    do next_slot(); while (bvalid);
    apply_write(`REG_FLASH_ADDR, d1, 4'hf);
    apply_write(`REG_FLASH_ADDR, d2, 4'hf);
    check_eq("flash_o", 160'(flash_o), 160'(flash_sh));
    axil_read(`REG_FLASH_ADDR);
  endtask

  initial begin
    #(NUM_TXN * 40 * CLK_PERIOD);
    $display("Timeout after %0d cycles, the DUT stopped responding", NUM_TXN * 40);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    seed_val     = $urandom(52);
    pcie_rst     = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    i2c_in       = '1;
    flash_dq     = '0;
    status_tag   = '0;
    status_valid = '0;
    gpio_sh      = '1;
    flash_sh     = '0;
    flash_sh.ce_n  = 1'b1;
    flash_sh.oe_n  = 1'b1;
    flash_sh.we_n  = 1'b1;
    flash_sh.adv_n = 1'b1;
    tag_acc[0]   = '0;
    tag_acc[1]   = '0;

    repeat (4) @(posedge pcie_clk);
    #DRIVE_DLY;
    pcie_rst = 1'b0;

    check_eq("i2c_o", 160'(i2c_o), 160'(gpio_sh));
    check_eq("flash_o", 160'(flash_o), 160'(flash_sh));
    check_eq("desc_valid", 160'(desc_valid), 160'(0));
    check_eq("bvalid", 160'(bvalid), 160'(0));
    check_eq("rvalid", 160'(rvalid), 160'(0));

    // ID block and the holes around it
    for (int a = 0; a <= 'h44; a += 4) axil_read(16'(a));
    axil_read(`REG_FLASH_ID);
    axil_read(16'h0200);
    axil_read(16'h7ffc);

    gpio_test();
    flash_test();
    desc_test(1'b0);
    desc_test(1'b1);
    status_test(1'b0);
    status_test(1'b1);
    blocked_write_test();
    repeat (2) next_slot();

    if (exp_q.size() != 0) begin
      $display("%0d reads never returned data", exp_q.size());
      $display("STATUS: FAIL");
      $fatal(1, "missing read responses");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- pcie_config.f
+incdir+rtl
rtl/pcie_config_pkg.sv
rtl/csr_axil_slave.sv
rtl/board_io_regs.sv
rtl/host_dma_channel.sv
rtl/pcie_config.sv
dv/pcie_config_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the pcie_config testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module pcie_config_tb \
  -f pcie_config.f \
  -o pcie_config_sim

# A $fatal in the testbench gives a failing exit status
./obj_dir/pcie_config_sim
